// ==== miniAluPkg.sv ====
package miniAluPkg;

	// Word sizes of the core
	localparam int dataWidth = 16;
	localparam int addrWidth = 8;
	localparam int instrWidth = 28;

	// Program and data stores hold one entry per 8-bit address
	localparam int progDepth = 256;
	localparam int dataDepth = 256;

	// Opcodes sit in the top nibble of every instruction word
	localparam logic [3:0] opNop = 4'd0;
	localparam logic [3:0] opAdd = 4'd1;
	localparam logic [3:0] opSub = 4'd2;
	localparam logic [3:0] opBle = 4'd3;
	localparam logic [3:0] opJmp = 4'd4;
	localparam logic [3:0] opCall = 4'd5;
	localparam logic [3:0] opRet = 4'd6;
	localparam logic [3:0] opLed = 4'd7;
	// Both top bits set marks an immediate-form instruction
	localparam logic [3:0] opSto = 4'd12;

	// Register form with two source addresses
	typedef struct packed {
		logic [3:0] op;
		logic [addrWidth-1:0] dest;
		logic [addrWidth-1:0] src1;
		logic [addrWidth-1:0] src0;
	} regForm_s;

	// In the immediate form the two source fields make one 16-bit value
	typedef struct packed {
		logic [3:0] op;
		logic [addrWidth-1:0] dest;
		logic [dataWidth-1:0] imm;
	} immForm_s;

	typedef union packed {
		regForm_s regForm;
		immForm_s immForm;
	} instructionWord_u;

endpackage

// ==== coreBuses.sv ====
`timescale 1ns/1ns

// Operand read path between the decode stage and the data memory
interface regReadBus;
	logic [miniAluPkg::addrWidth-1:0] readAddr0;
	logic [miniAluPkg::addrWidth-1:0] readAddr1;
	logic [miniAluPkg::dataWidth-1:0] readData0;
	logic [miniAluPkg::dataWidth-1:0] readData1;

	modport core (
		output readAddr0,
		output readAddr1,
		input readData0,
		input readData1
	);

	modport memory (
		input readAddr0,
		input readAddr1,
		output readData0,
		output readData1
	);
endinterface

// Program flow controls from the execute stage to the pointer
interface flowBus;
	logic branchTaken;
	logic [miniAluPkg::addrWidth-1:0] branchTarget;
	logic isCall;
	logic isReturn;

	modport control (output branchTaken, output branchTarget, output isCall, output isReturn);

	modport pointer (input branchTaken, input branchTarget, input isCall, input isReturn);
endinterface

// ==== programMemory.sv ====
`timescale 1ns/1ns

module programMemory
(
	input logic Clock,
	input logic rst,
	input logic progWrite,
	input logic [miniAluPkg::addrWidth-1:0] progAddr,
	input logic [miniAluPkg::instrWidth-1:0] progData,
	input logic [miniAluPkg::addrWidth-1:0] readAddr,
	output miniAluPkg::instructionWord_u instruction
);

	logic [miniAluPkg::instrWidth-1:0] words [miniAluPkg::progDepth];

	// The loader may only write while the core is held in reset
	always_ff @(posedge Clock)
	begin
		if (rst && progWrite)
		begin
			words[progAddr] <= progData;
		end
	end

	// Fetch is combinational so a redirect reaches decode in the same cycle
	assign instruction = words[readAddr];

endmodule

// ==== dataMemory.sv ====
`timescale 1ns/1ns

module dataMemory
(
	input logic Clock,
	regReadBus.memory readBus,
	input logic writeEnable,
	input logic [miniAluPkg::addrWidth-1:0] writeAddr,
	input logic [miniAluPkg::dataWidth-1:0] writeData
);

	logic [miniAluPkg::dataWidth-1:0] words [miniAluPkg::dataDepth];

	// Both reads are registered and see the contents before this edge's write
	always_ff @(posedge Clock)
	begin
		readBus.readData0 <= words[readBus.readAddr0];
		readBus.readData1 <= words[readBus.readAddr1];
	end

	// The single write port is driven by the execute stage
	always_ff @(posedge Clock)
	begin
		if (writeEnable)
		begin
			words[writeAddr] <= writeData;
		end
	end

endmodule

// ==== instructionPointer.sv ====
`timescale 1ns/1ns

module instructionPointer
(
	input logic Clock,
	input logic rst,
	flowBus.pointer flow,
	output logic [miniAluPkg::addrWidth-1:0] fetchAddr
);

	logic [miniAluPkg::addrWidth-1:0] count;
	logic [miniAluPkg::addrWidth-1:0] returnAddr;

	// A taken branch overrides the count in the same cycle
	always_comb
	begin
		if (flow.branchTaken)
		begin
			if (flow.isReturn)
			begin
				fetchAddr = returnAddr;
			end
			else
			begin
				fetchAddr = flow.branchTarget;
			end
		end
		else
		begin
			fetchAddr = count;
		end
	end

	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			count <= '0;
		end
		else
		begin
			count <= fetchAddr + 8'd1;
		end
	end

	// While a call executes, count already points past the call
	always_ff @(posedge Clock)
	begin
		if (flow.isCall)
		begin
			returnAddr <= count;
		end
	end

endmodule

// ==== executeUnit.sv ====
`timescale 1ns/1ns

module executeUnit
(
	input logic Clock,
	input logic rst,
	input miniAluPkg::instructionWord_u instruction,
	regReadBus.core readBus,
	flowBus.control flow,
	output logic writeEnable,
	output logic [miniAluPkg::addrWidth-1:0] writeAddr,
	output logic [miniAluPkg::dataWidth-1:0] writeData,
	output logic [7:0] led
);

	miniAluPkg::instructionWord_u decoded;
	logic isImmediate;
	logic hazard0;
	logic hazard1;
	logic [miniAluPkg::dataWidth-1:0] operand0;
	logic [miniAluPkg::dataWidth-1:0] operand1;
	logic [miniAluPkg::dataWidth-1:0] result;
	logic ledEnable;
	logic prevWrite;
	logic [miniAluPkg::addrWidth-1:0] prevDest;
	logic [miniAluPkg::dataWidth-1:0] prevResult;

	// Operand addresses leave straight from the fetched word
	assign readBus.readAddr0 = instruction.regForm.src0;
	assign readBus.readAddr1 = instruction.regForm.src1;

	// The decode register holds the fetched word for the execute cycle
	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			decoded.regForm.op <= miniAluPkg::opNop;
		end
		else
		begin
			decoded <= instruction;
		end
	end

	// The memory missed last cycle's write, so take the previous result instead
	assign isImmediate = decoded.regForm.op[3] & decoded.regForm.op[2];
	assign hazard0 = prevWrite && (prevDest == decoded.regForm.src0) && !isImmediate;
	assign hazard1 = prevWrite && (prevDest == decoded.regForm.src1) && !isImmediate;
	assign operand0 = hazard0 ? prevResult : readBus.readData0;
	assign operand1 = hazard1 ? prevResult : readBus.readData1;

	always_comb
	begin
		writeEnable = 1'b0;
		result = '0;
		ledEnable = 1'b0;
		flow.branchTaken = 1'b0;
		flow.isCall = 1'b0;
		flow.isReturn = 1'b0;
		case (decoded.regForm.op)
			miniAluPkg::opAdd:
			begin
				writeEnable = 1'b1;
				result = operand1 + operand0;
			end
			miniAluPkg::opSub:
			begin
				writeEnable = 1'b1;
				result = operand1 - operand0;
			end
			miniAluPkg::opSto:
			begin
				writeEnable = 1'b1;
				result = decoded.immForm.imm;
			end
			miniAluPkg::opBle:
			begin
				flow.branchTaken = (operand1 <= operand0);
			end
			miniAluPkg::opJmp:
			begin
				flow.branchTaken = 1'b1;
			end
			miniAluPkg::opCall:
			begin
				flow.branchTaken = 1'b1;
				flow.isCall = 1'b1;
			end
			miniAluPkg::opRet:
			begin
				flow.branchTaken = 1'b1;
				flow.isReturn = 1'b1;
			end
			miniAluPkg::opLed:
			begin
				ledEnable = 1'b1;
			end
			default:
			begin
				// Nop and undefined opcodes leave everything idle
				writeEnable = 1'b0;
			end
		endcase
	end

	// Branch targets share the dest field
	assign flow.branchTarget = decoded.regForm.dest;
	assign writeAddr = decoded.regForm.dest;
	assign writeData = result;

	// Forwarding history of the instruction just completed
	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			prevWrite <= 1'b0;
		end
		else
		begin
			prevWrite <= writeEnable;
		end
	end

	always_ff @(posedge Clock)
	begin
		prevDest <= writeAddr;
		prevResult <= result;
	end

	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			led <= 8'd0;
		end
		else if (ledEnable)
		begin
			led <= operand1[7:0];
		end
	end

endmodule

// ==== miniAlu.sv ====
`timescale 1ns/1ns

module miniAlu
(
	input logic Clock,
	input logic rst,
	input logic progWrite,
	input logic [miniAluPkg::addrWidth-1:0] progAddr,
	input logic [miniAluPkg::instrWidth-1:0] progData,
	output logic [7:0] led
);

	miniAluPkg::instructionWord_u instruction;
	logic [miniAluPkg::addrWidth-1:0] fetchAddr;
	logic writeEnable;
	logic [miniAluPkg::addrWidth-1:0] writeAddr;
	logic [miniAluPkg::dataWidth-1:0] writeData;

	regReadBus readBus();
	flowBus flow();

	programMemory i_programMemory
	(
		.Clock(Clock),
		.rst(rst),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.readAddr(fetchAddr),
		.instruction(instruction)
	);

	instructionPointer i_instructionPointer
	(
		.Clock(Clock),
		.rst(rst),
		.flow(flow.pointer),
		.fetchAddr(fetchAddr)
	);

	dataMemory i_dataMemory
	(
		.Clock(Clock),
		.readBus(readBus.memory),
		.writeEnable(writeEnable),
		.writeAddr(writeAddr),
		.writeData(writeData)
	);

	executeUnit i_executeUnit
	(
		.Clock(Clock),
		.rst(rst),
		.instruction(instruction),
		.readBus(readBus.core),
		.flow(flow.control),
		.writeEnable(writeEnable),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.led(led)
	);

endmodule

// ==== miniAlu_assertions.sv ====
`timescale 1ns/1ns

module miniAluChecks
(
	input logic Clock,
	input logic rst,
	input logic progWrite,
	input logic [7:0] led,
	input logic [7:0] fetchAddr
);

	ledClearedByReset: assert property (@(posedge Clock) rst |=> (led == 8'd0))
		else $error("led is not zero one cycle after reset was high");

	// The program store is only loaded while the core is held
	loadOnlyInReset: assert property (@(posedge Clock) !rst |-> !progWrite)
		else $error("program write seen while reset is low");

	// Execution resumes from address 0 once reset is released
	firstFetchAtZero: assert property (@(posedge Clock) $fell(rst) |-> (fetchAddr == 8'd0))
		else $error("first fetch after reset is not at address 0");

endmodule

bind miniAlu miniAluChecks i_miniAluChecks
(
	.Clock(Clock),
	.rst(rst),
	.progWrite(progWrite),
	.led(led),
	.fetchAddr(fetchAddr)
);

// ==== tbMiniAlu.sv ====
`timescale 1ns/1ns

module tbMiniAlu;

	// Thirteen program runs of about 215 cycles each come to roughly 2800 cycles
	localparam int cycleLimit = 3000;

	logic Clock;
	logic rst;
	logic progWrite;
	logic [7:0] progAddr;
	logic [27:0] progData;
	logic [7:0] led;

	logic [27:0] progWords [$];
	logic [31:0] rngState;
	int cycleCount;
	int passCount;
	int failCount;
	logic testFailed;

	miniAlu i_miniAlu
	(
		.Clock(Clock),
		.rst(rst),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.led(led)
	);

	always #20 Clock = ~Clock;

	always @(posedge Clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Run stopped because no result came within %0d clock cycles", cycleLimit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic pushReg(input logic [3:0] op, input logic [7:0] dest,
		input logic [7:0] src1, input logic [7:0] src0);
		miniAluPkg::instructionWord_u word;
		word.regForm.op = op;
		word.regForm.dest = dest;
		word.regForm.src1 = src1;
		word.regForm.src0 = src0;
		progWords.push_back(word);
	endtask

	task automatic pushImm(input logic [7:0] dest, input logic [15:0] imm);
		miniAluPkg::instructionWord_u word;
		word.immForm.op = miniAluPkg::opSto;
		word.immForm.dest = dest;
		word.immForm.imm = imm;
		progWords.push_back(word);
	endtask

	// Loads the queued words under reset, then lets the core run
	task automatic runProgram();
		rst = 1'b1;
		foreach (progWords[i])
		begin
			progWrite = 1'b1;
			progAddr = 8'(i);
			progData = progWords[i];
			@(posedge Clock);
			#5;
		end
		progWrite = 1'b0;
		repeat (10) @(posedge Clock);
		#5;
		rst = 1'b0;
		repeat (200) @(posedge Clock);
		#5;
		progWords.delete();
	endtask

	task automatic checkLed(input string name, input logic [7:0] expected);
		if (led !== expected)
		begin
			$display("error %s expected %h actual %h", name, expected, led);
			testFailed = 1'b1;
		end
	endtask

	task automatic finishTest(input string name);
		if (testFailed)
		begin
			failCount++;
			$display("%s failed", name);
		end
		else
		begin
			passCount++;
			$display("%s passed", name);
		end
		testFailed = 1'b0;
	endtask

	task automatic resetTest();
		rst = 1'b1;
		repeat (10) @(posedge Clock);
		#5;
		checkLed("reset", 8'h00);
		finishTest("reset");
	endtask

	task automatic storeShowTest();
		logic [15:0] value;
		value = 16'h3c96;
		pushImm(8'h10, value);
		pushReg(miniAluPkg::opLed, 8'h00, 8'h10, 8'h00);
		pushReg(miniAluPkg::opJmp, 8'd2, 8'h00, 8'h00);
		runProgram();
		checkLed("storeShow", value[7:0]);
		// High byte goes in src1 and low byte in src0
		pushReg(miniAluPkg::opSto, 8'h11, 8'h12, 8'hab);
		pushReg(miniAluPkg::opLed, 8'h00, 8'h11, 8'h00);
		pushReg(miniAluPkg::opJmp, 8'd2, 8'h00, 8'h00);
		runProgram();
		checkLed("storeShow", 8'hab);
		finishTest("storeShow");
	endtask

	task automatic backToBackTest();
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] sum;
		logic [15:0] diff;
		a = 16'h01f3;
		b = 16'h0098;
		sum = a + b;
		diff = sum - b;
		pushImm(8'h20, a);
		pushImm(8'h21, b);
		pushReg(miniAluPkg::opAdd, 8'h22, 8'h20, 8'h21);
		pushReg(miniAluPkg::opSub, 8'h23, 8'h22, 8'h21);
		pushReg(miniAluPkg::opLed, 8'h00, 8'h23, 8'h00);
		pushReg(miniAluPkg::opJmp, 8'd5, 8'h00, 8'h00);
		runProgram();
		checkLed("backToBack", diff[7:0]);
		finishTest("backToBack");
	endtask

	task automatic branchLoopTest();
		logic [15:0] limit;
		logic [15:0] expectedCount;
		limit = 16'd20;
		expectedCount = limit + 16'd1;
		pushImm(8'h30, 16'd0);
		pushImm(8'h31, 16'd1);
		pushImm(8'h32, limit);
		pushReg(miniAluPkg::opAdd, 8'h30, 8'h30, 8'h31);
		pushReg(miniAluPkg::opBle, 8'd6, 8'h30, 8'h32);
		pushReg(miniAluPkg::opJmp, 8'd8, 8'h00, 8'h00);
		pushReg(miniAluPkg::opJmp, 8'd3, 8'h00, 8'h00);
		// Would add an extra count if the word after the jump back ran
		pushReg(miniAluPkg::opAdd, 8'h30, 8'h30, 8'h31);
		pushReg(miniAluPkg::opLed, 8'h00, 8'h30, 8'h00);
		pushReg(miniAluPkg::opJmp, 8'd9, 8'h00, 8'h00);
		runProgram();
		checkLed("branchLoop", expectedCount[7:0]);
		finishTest("branchLoop");
	endtask

	task automatic callReturnTest();
		pushImm(8'h40, 16'h0011);
		pushReg(miniAluPkg::opCall, 8'd5, 8'h00, 8'h00);
		pushReg(miniAluPkg::opLed, 8'h00, 8'h40, 8'h00);
		pushReg(miniAluPkg::opJmp, 8'd3, 8'h00, 8'h00);
		pushImm(8'h40, 16'h00ee);
		// Subroutine body and return
		pushImm(8'h40, 16'h005a);
		pushReg(miniAluPkg::opRet, 8'h00, 8'h00, 8'h00);
		pushImm(8'h40, 16'h00ee);
		runProgram();
		checkLed("callReturn", 8'h5a);
		finishTest("callReturn");
	endtask

	task automatic randomSumTest();
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] sum;
		for (int i = 0; i < 8; i++)
		begin
			rngState = xorshift32(rngState);
			a = rngState[15:0];
			rngState = xorshift32(rngState);
			b = rngState[15:0];
			sum = a + b;
			pushImm(8'h50, a);
			pushImm(8'h51, b);
			pushReg(miniAluPkg::opAdd, 8'h52, 8'h50, 8'h51);
			pushReg(miniAluPkg::opLed, 8'h00, 8'h52, 8'h00);
			pushReg(miniAluPkg::opJmp, 8'd4, 8'h00, 8'h00);
			runProgram();
			checkLed("randomSum", sum[7:0]);
		end
		finishTest("randomSum");
	endtask

	initial
	begin
		Clock = 1'b0;
		rst = 1'b1;
		progWrite = 1'b0;
		progAddr = 8'h00;
		progData = 28'h0;
		rngState = 32'hb6d065bb;
		cycleCount = 0;
		passCount = 0;
		failCount = 0;
		testFailed = 1'b0;
		@(posedge Clock);
		#5;
		// Reset is checked while led still shows the last stored byte
		storeShowTest();
		resetTest();
		backToBackTest();
		branchLoopTest();
		callReturnTest();
		randomSumTest();
		$display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
		if (failCount == 0)
		begin
			$display("TEST RESULT: PASS");
		end
		else
		begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== files.f ====
miniAluPkg.sv
coreBuses.sv
programMemory.sv
dataMemory.sv
instructionPointer.sv
executeUnit.sv
miniAlu.sv
miniAlu_assertions.sv
tbMiniAlu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tbMiniAlu -f files.f -o simMiniAlu
./obj_dir/simMiniAlu | tee sim.log
if grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
